// File: tc257_pkg.sv
//##########################################################
// 1.6TBASE-R 256B/257B receive transcoder shared definitions
// Widths, vector types, lane modes and 66B block types
//##########################################################
`default_nettype none

package tc257_pkg;

    // 64B/66B side
    localparam int LANE_W   = 64;
    localparam int SH_W     = 2;
    localparam int FRAME_W  = LANE_W + SH_W;
    localparam int LANES    = 4;
    // 256B/257B side, one header bit
    localparam int XBLOCK_W = LANES * LANE_W + 1;
    // One lane slice plus the 4-bit flag shift
    localparam int WINDOW_W = LANE_W + 4;
    localparam int COUNT_W  = 32;

    typedef logic [XBLOCK_W-1:0] xblock_t;
    // Sync header in bits 1:0, payload above
    typedef logic [FRAME_W-1:0]  frame_t;
    typedef logic [LANE_W-1:0]   payload_t;
    typedef logic [WINDOW_W-1:0] window_t;
    typedef logic [COUNT_W-1:0]  count_t;

    // Where a lane sits relative to the first control lane
    typedef enum logic [1:0] {
        LANE_EARLY_DATA,
        LANE_FIRST_CTRL,
        LANE_LATE
    } lane_mode_t;

    localparam logic [SH_W-1:0] SH_DATA = 2'b10;
    localparam logic [SH_W-1:0] SH_CTRL = 2'b01;
    localparam logic [SH_W-1:0] SH_BAD  = 2'b11;

    // Valid 66B block types, low nibble is the 257B compressed code
    localparam logic [7:0] BT_1E = 8'h1E;
    localparam logic [7:0] BT_78 = 8'h78;
    localparam logic [7:0] BT_4B = 8'h4B;
    localparam logic [7:0] BT_87 = 8'h87;
    localparam logic [7:0] BT_99 = 8'h99;
    localparam logic [7:0] BT_AA = 8'hAA;
    localparam logic [7:0] BT_B4 = 8'hB4;
    localparam logic [7:0] BT_CC = 8'hCC;
    localparam logic [7:0] BT_D2 = 8'hD2;
    localparam logic [7:0] BT_E1 = 8'hE1;
    localparam logic [7:0] BT_FF = 8'hFF;

endpackage

`default_nettype wire

// File: tc257_status_if.sv
//##########################################################
// Per-block classification strobes, decoder to counters
//##########################################################
`default_nettype none

interface tc257_status_if;

    // One-cycle strobes, aligned with the registered frames
    logic all_data;
    logic ctrl;
    logic format_err;
    logic sh_err;

    modport source (output all_data, ctrl, format_err, sh_err);
    modport sink   (input  all_data, ctrl, format_err, sh_err);

endinterface

`default_nettype wire

// File: tc257_lane_expander.sv
//##########################################################
// Lane expander, rebuilds one 66B block from a 257B lane window
// Restores compressed block types and flags unknown ones
//##########################################################
`default_nettype none

module tc257_lane_expander
    import tc257_pkg::*;
(
    input  window_t    i_window,
    input  lane_mode_t i_mode,
    input  logic       i_is_data,
    output frame_t     o_frame,
    output logic       o_format_err
);

    logic [7:0]      type_byte;
    logic            type_known;
    payload_t        payload;
    logic [SH_W-1:0] sh;

    // Unknown codes come back with a zero high nibble, never a valid type
    function automatic logic [7:0] restore_type(input logic [3:0] code);
        logic [7:0] full;
        case (code)
            BT_1E[3:0]: full = BT_1E;
            BT_78[3:0]: full = BT_78;
            BT_4B[3:0]: full = BT_4B;
            BT_87[3:0]: full = BT_87;
            BT_99[3:0]: full = BT_99;
            BT_AA[3:0]: full = BT_AA;
            BT_B4[3:0]: full = BT_B4;
            BT_CC[3:0]: full = BT_CC;
            BT_D2[3:0]: full = BT_D2;
            BT_E1[3:0]: full = BT_E1;
            BT_FF[3:0]: full = BT_FF;
            default:    full = {4'h0, code};
        endcase
        return full;
    endfunction

    function automatic logic is_known_type(input logic [7:0] bt);
        logic known;
        case (bt)
            BT_1E, BT_78, BT_4B, BT_87, BT_99, BT_AA,
            BT_B4, BT_CC, BT_D2, BT_E1, BT_FF: known = 1'b1;
            default:                           known = 1'b0;
        endcase
        return known;
    endfunction

    // Only the first control lane carries a compressed type
    assign type_byte  = (i_mode == LANE_FIRST_CTRL) ? restore_type(i_window[7:4])
                                                    : i_window[7:0];
    assign type_known = is_known_type(type_byte);

    always_comb begin
        case (i_mode)
            // Shifted up by the 4 flag bits
            LANE_EARLY_DATA: payload = i_window[WINDOW_W-1 -: LANE_W];
            LANE_FIRST_CTRL: payload = {i_window[LANE_W-1:8], type_byte};
            default:         payload = i_window[LANE_W-1:0];
        endcase
    end

    always_comb begin
        if (i_is_data) begin
            sh = SH_DATA;
        end else if (type_known) begin
            sh = SH_CTRL;
        end else begin
            sh = SH_BAD;
        end
    end

    assign o_frame      = {payload, sh};
    assign o_format_err = !i_is_data && !type_known;

endmodule

`default_nettype wire

// File: tc257_block_decoder.sv
//##########################################################
// 257B block decoder, classifies and expands into four 66B blocks
// Frames and status strobes are registered together
//##########################################################
`default_nettype none

module tc257_block_decoder
    import tc257_pkg::*;
(
    input  logic           clk,
    input  logic           i_rst,
    input  xblock_t        i_xblock,
    output frame_t         o_frame_0,
    output frame_t         o_frame_1,
    output frame_t         o_frame_2,
    output frame_t         o_frame_3,
    tc257_status_if.source stat
);

    logic [LANES-1:0]                    flags;
    logic                                all_data;
    logic                                sh_fault;
    logic                                ctrl_seen;
    logic [XBLOCK_W+WINDOW_W-LANE_W-1:0] padded;
    logic [LANES*LANE_W-1:0]             bad_payload;
    lane_mode_t                          lane_mode [LANES];
    frame_t                              lane_frame [LANES];
    logic [LANES-1:0]                    lane_fmt_err;
    frame_t                              next_frame [LANES];
    frame_t                              frame_q [LANES];

    assign all_data = i_xblock[0];
    // Flag bit set means a data lane
    assign flags    = i_xblock[LANES:1];
    assign sh_fault = !all_data && (flags == '1);

    // Last lane window runs past bit 256
    assign padded      = {{(WINDOW_W - LANE_W){1'b0}}, i_xblock};
    assign bad_payload = {i_xblock[XBLOCK_W-1:9], 4'h0, i_xblock[8:5]};

    always_comb begin
        ctrl_seen = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            if (ctrl_seen) begin
                lane_mode[i] = LANE_LATE;
            end else if (!flags[i]) begin
                lane_mode[i] = LANE_FIRST_CTRL;
            end else begin
                lane_mode[i] = LANE_EARLY_DATA;
            end
            ctrl_seen = ctrl_seen || !flags[i];
        end
    end

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        tc257_lane_expander u_expander (
            .i_window     (padded[1 + LANE_W*i +: WINDOW_W]),
            .i_mode       (lane_mode[i]),
            .i_is_data    (flags[i]),
            .o_frame      (lane_frame[i]),
            .o_format_err (lane_fmt_err[i])
        );
    end

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            if (all_data) begin
                next_frame[i] = {i_xblock[1 + LANE_W*i +: LANE_W], SH_DATA};
            end else if (sh_fault) begin
                // Alternating 00/11 headers mark the broken block
                next_frame[i] = {bad_payload[LANE_W*i +: LANE_W],
                                 ((i % 2 == 1) ? SH_BAD : {SH_W{1'b0}})};
            end else begin
                next_frame[i] = lane_frame[i];
            end
        end
    end

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            frame_q         <= '{default: '0};
            stat.all_data   <= 1'b0;
            stat.ctrl       <= 1'b0;
            stat.format_err <= 1'b0;
            stat.sh_err     <= 1'b0;
        end else begin
            frame_q         <= next_frame;
            stat.all_data   <= all_data;
            stat.ctrl       <= !all_data;
            stat.format_err <= !all_data && !sh_fault && (|lane_fmt_err);
            stat.sh_err     <= sh_fault;
        end
    end

    assign o_frame_0 = frame_q[0];
    assign o_frame_1 = frame_q[1];
    assign o_frame_2 = frame_q[2];
    assign o_frame_3 = frame_q[3];

endmodule

`default_nettype wire

// File: tc257_stat_counters.sv
//##########################################################
// Receive statistics, six free-running block counters
//##########################################################
`default_nettype none

module tc257_stat_counters
    import tc257_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst,
    tc257_status_if.sink stat,
    output count_t       o_block_count,
    output count_t       o_data_count,
    output count_t       o_ctrl_count,
    output count_t       o_inv_block_count,
    output count_t       o_inv_format_count,
    output count_t       o_inv_sh_count
);

    logic inv_block;

    // A block is invalid on either error kind
    assign inv_block = stat.format_err || stat.sh_err;

    always_ff @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            o_block_count      <= '0;
            o_data_count       <= '0;
            o_ctrl_count       <= '0;
            o_inv_block_count  <= '0;
            o_inv_format_count <= '0;
            o_inv_sh_count     <= '0;
        end else begin
            // One block arrives on every edge
            o_block_count      <= o_block_count + count_t'(1);
            o_data_count       <= o_data_count + count_t'(stat.all_data);
            o_ctrl_count       <= o_ctrl_count + count_t'(stat.ctrl);
            o_inv_block_count  <= o_inv_block_count + count_t'(inv_block);
            o_inv_format_count <= o_inv_format_count + count_t'(stat.format_err);
            o_inv_sh_count     <= o_inv_sh_count + count_t'(stat.sh_err);
        end
    end

endmodule

`default_nettype wire

// File: tc257_rx_checker.sv
//##########################################################
// 1.6TBASE-R 257B receive checker, decoder plus statistics
//##########################################################
`default_nettype none

module tc257_rx_checker
    import tc257_pkg::*;
(
    input  logic    clk,
    input  logic    i_rst,
    input  xblock_t i_rx_xcoded,
    output frame_t  o_rx_coded_0,
    output frame_t  o_rx_coded_1,
    output frame_t  o_rx_coded_2,
    output frame_t  o_rx_coded_3,
    output count_t  o_block_count,
    output count_t  o_data_count,
    output count_t  o_ctrl_count,
    output count_t  o_inv_block_count,
    output count_t  o_inv_format_count,
    output count_t  o_inv_sh_count
);

    // Strobes trail the input by one cycle, counters by two
    tc257_status_if stat_if ();

    tc257_block_decoder u_decoder (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_xblock  (i_rx_xcoded),
        .o_frame_0 (o_rx_coded_0),
        .o_frame_1 (o_rx_coded_1),
        .o_frame_2 (o_rx_coded_2),
        .o_frame_3 (o_rx_coded_3),
        .stat      (stat_if.source)
    );

    tc257_stat_counters u_counters (
        .clk                (clk),
        .i_rst              (i_rst),
        .stat               (stat_if.sink),
        .o_block_count      (o_block_count),
        .o_data_count       (o_data_count),
        .o_ctrl_count       (o_ctrl_count),
        .o_inv_block_count  (o_inv_block_count),
        .o_inv_format_count (o_inv_format_count),
        .o_inv_sh_count     (o_inv_sh_count)
    );

endmodule

`default_nettype wire

// File: tc257_tb_model.svh
//##########################################################
// Testbench reference model and 257B block builders
//##########################################################
`ifndef TC257_TB_MODEL_SVH
`define TC257_TB_MODEL_SVH

// Valid 66B block types with entry k at bits 8k+7:8k
localparam logic [87:0] TYPE_TABLE = {BT_FF, BT_E1, BT_D2, BT_CC, BT_B4, BT_AA,
                                      BT_99, BT_87, BT_4B, BT_78, BT_1E};
// Compressed codes that have no 66B block type
localparam logic [19:0] UNKNOWN_CODES = 20'h0356D;

function automatic logic type_valid(input logic [7:0] bt);
    for (int k = 0; k < 11; k++) begin
        if (TYPE_TABLE[8*k +: 8] == bt)
            return 1'b1;
    end
    return 1'b0;
endfunction

// Unknown codes keep a zero high nibble
function automatic logic [7:0] full_type(input logic [3:0] code);
    for (int k = 0; k < 11; k++) begin
        if (TYPE_TABLE[8*k +: 4] == code)
            return TYPE_TABLE[8*k +: 8];
    end
    return {4'h0, code};
endfunction

function automatic frame_t expect_frame(input xblock_t x, input int lane);
    logic [XBLOCK_W+3:0] px;
    logic [255:0]        bad;
    logic [7:0]          bt;
    int                  first;
    px    = {4'h0, x};
    bad   = {x[256:9], 4'h0, x[8:5]};
    first = LANES;
    for (int i = LANES - 1; i >= 0; i--) begin
        if (!x[1+i])
            first = i;
    end
    if (x[0])
        return {x[1+64*lane +: 64], SH_DATA};
    if (x[4:1] == 4'hF)
        return {bad[64*lane +: 64], (lane % 2 == 1) ? 2'b11 : 2'b00};
    // Data lanes ahead of the first control lane sit 4 bits higher
    if (lane < first)
        return {px[5+64*lane +: 64], SH_DATA};
    if (lane == first) begin
        bt = full_type(x[5+64*lane +: 4]);
        return {x[9+64*lane +: 56], bt, type_valid(bt) ? SH_CTRL : SH_BAD};
    end
    if (x[1+lane])
        return {x[1+64*lane +: 64], SH_DATA};
    bt = x[1+64*lane +: 8];
    return {x[1+64*lane +: 64], type_valid(bt) ? SH_CTRL : SH_BAD};
endfunction

// Delta bits from low to high are block, data, ctrl, invalid block,
// format error and sync header error
function automatic logic [5:0] expect_deltas(input xblock_t x);
    logic   sh;
    logic   fmt;
    frame_t f;
    sh  = !x[0] && (x[4:1] == 4'hF);
    fmt = 1'b0;
    for (int i = 0; i < LANES; i++) begin
        f = expect_frame(x, i);
        if (!x[0] && !sh && f[1:0] == SH_BAD)
            fmt = 1'b1;
    end
    return {sh, fmt, fmt || sh, !x[0], x[0], 1'b1};
endfunction

function automatic xblock_t rand_xblock();
    xblock_t x;
    x = '0;
    for (int k = 0; k < 9; k++)
        x = {x[XBLOCK_W-33:0], 32'($random(seed))};
    return x;
endfunction

// Control block with one code for the first control lane and one type for late ones
function automatic xblock_t make_ctrl(input logic [3:0] flags, input logic [3:0] code,
                                      input logic [7:0] late_type);
    xblock_t x;
    int      first;
    x      = rand_xblock();
    x[0]   = 1'b0;
    x[4:1] = flags;
    first  = LANES;
    for (int i = LANES - 1; i >= 0; i--) begin
        if (!flags[i])
            first = i;
    end
    x[5+64*first +: 4] = code;
    for (int i = first + 1; i < LANES; i++) begin
        if (!flags[i])
            x[1+64*i +: 8] = late_type;
    end
    return x;
endfunction

`endif

// File: tc257_rx_checker_tb.sv
//##########################################################
// Testbench for the 257B receive checker
// Drives every block kind, checks frames and statistics
//##########################################################
`default_nettype none

module tc257_rx_checker_tb
    import tc257_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Reset, test blocks and drain cycles
    localparam int N_BLOCKS = 2 + 16 + LANES*11 + 16 + LANES*5 + 8 + 8 + 4;

    logic    clk;
    logic    i_rst;
    xblock_t i_rx_xcoded;
    frame_t  act_frame [LANES];
    frame_t  exp_frame [LANES];
    count_t  act_cnt [6];
    count_t  exp_cnt [6];
    logic [5:0] delta_q;
    logic    outs_zero;
    int      errors;
    integer  seed;
    string   test_name;
    string   cnt_name [6] = '{"block", "data", "ctrl", "inv_block", "inv_format", "inv_sh"};

    `include "tc257_tb_model.svh"

    initial clk = 1'b0;
    always #50 clk = ~clk;

    tc257_rx_checker dut_i (
        .clk                (clk),
        .i_rst              (i_rst),
        .i_rx_xcoded        (i_rx_xcoded),
        .o_rx_coded_0       (act_frame[0]),
        .o_rx_coded_1       (act_frame[1]),
        .o_rx_coded_2       (act_frame[2]),
        .o_rx_coded_3       (act_frame[3]),
        .o_block_count      (act_cnt[0]),
        .o_data_count       (act_cnt[1]),
        .o_ctrl_count       (act_cnt[2]),
        .o_inv_block_count  (act_cnt[3]),
        .o_inv_format_count (act_cnt[4]),
        .o_inv_sh_count     (act_cnt[5])
    );

    // Expected frames one cycle after input, counts one cycle later
    always @(posedge clk or posedge i_rst) begin
        if (i_rst) begin
            exp_frame <= '{default: '0};
            exp_cnt   <= '{default: '0};
            delta_q   <= '0;
        end else begin
            for (int i = 0; i < LANES; i++)
                exp_frame[i] <= expect_frame(i_rx_xcoded, i);
            delta_q    <= expect_deltas(i_rx_xcoded);
            exp_cnt[0] <= exp_cnt[0] + 1;
            for (int k = 1; k < 6; k++)
                exp_cnt[k] <= exp_cnt[k] + count_t'(delta_q[k]);
        end
    end

    assign outs_zero = ((act_frame[0] | act_frame[1] | act_frame[2] | act_frame[3]) == '0)
                    && ((act_cnt[0] | act_cnt[1] | act_cnt[2] | act_cnt[3]
                         | act_cnt[4] | act_cnt[5]) == '0);

    a_reset: assert property (@(posedge clk) i_rst |-> outs_zero)
        else begin
            errors++;
            $display("Outputs are not zero while reset is held");
        end

    for (genvar i = 0; i < LANES; i++) begin : g_frame_chk
        a_frame: assert property (@(posedge clk) act_frame[i] == exp_frame[i])
            else begin
                errors++;
                $display("[ERROR] %s lane %0d expected %h actual %h", test_name, i,
                         $sampled(exp_frame[i]), $sampled(act_frame[i]));
            end
    end

    for (genvar k = 0; k < 6; k++) begin : g_count_chk
        a_count: assert property (@(posedge clk) act_cnt[k] == exp_cnt[k])
            else begin
                errors++;
                $display("[ERROR] %s %s count expected %0d actual %0d", test_name,
                         cnt_name[k], $sampled(exp_cnt[k]), $sampled(act_cnt[k]));
            end
    end

    task automatic drive(input xblock_t x);
        i_rx_xcoded = x;
        @(posedge clk);
        #5;
    endtask

    initial begin
        xblock_t    x;
        logic [3:0] flags;
        logic [7:0] bt;
        seed        = 32'hba6e;
        errors      = 0;
        i_rst       = 1'b0;
        i_rx_xcoded = '0;
        test_name   = "reset";
        #1;
        i_rst = 1'b1;
        repeat (2) @(posedge clk);
        #5;
        i_rst = 1'b0;

        test_name = "all_data";
        repeat (16) begin
            x    = rand_xblock();
            x[0] = 1'b1;
            drive(x);
        end

        // Every code at every first-control position
        test_name = "first_ctrl";
        for (int f = 0; f < LANES; f++)
            for (int k = 0; k < 11; k++)
                drive(make_ctrl(4'hF & ~(4'b1 << f), TYPE_TABLE[8*k +: 4], BT_1E));

        test_name = "late_lanes";
        repeat (16) begin
            flags = 4'($random(seed));
            if (flags == 4'hF)
                flags = 4'h0;
            drive(make_ctrl(flags, TYPE_TABLE[8*($unsigned($random(seed)) % 11) +: 4],
                            TYPE_TABLE[8*($unsigned($random(seed)) % 11) +: 8]));
        end

        test_name = "unknown_first";
        for (int f = 0; f < LANES; f++)
            for (int k = 0; k < 5; k++)
                drive(make_ctrl(4'hF & ~(4'b1 << f), UNKNOWN_CODES[4*k +: 4], BT_FF));

        test_name = "unknown_late";
        for (int n = 0; n < 8; n++) begin
            do
                bt = 8'($random(seed));
            while (type_valid(bt));
            drive(make_ctrl((n % 2 == 1) ? 4'b1010 : 4'b0000, BT_CC[3:0], bt));
        end

        test_name = "flags_1111";
        repeat (8) begin
            x      = rand_xblock();
            x[0]   = 1'b0;
            x[4:1] = 4'hF;
            drive(x);
        end

        // Let the counters catch up with the last blocks
        test_name = "drain";
        repeat (4) begin
            x    = rand_xblock();
            x[0] = 1'b1;
            drive(x);
        end

        $display("Checks finished with %0d errors", errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        #((N_BLOCKS + 20) * 100);
        $display("Watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
tc257_pkg.sv
tc257_status_if.sv
tc257_lane_expander.sv
tc257_block_decoder.sv
tc257_stat_counters.sv
tc257_rx_checker.sv
tc257_rx_checker_tb.sv

// File: Bender.yml
package:
  name: tc257_rx_checker

sources:
  - tc257_pkg.sv
  - tc257_status_if.sv
  - tc257_lane_expander.sv
  - tc257_block_decoder.sv
  - tc257_stat_counters.sv
  - tc257_rx_checker.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tc257_rx_checker_tb.sv
